/* files.f */
+incdir+verilog
verilog/riscv_isa_pkg.sv
verilog/debug_pkg.sv
verilog/rf_operand_decode.sv
verilog/riscv_rf.sv
verilog/rf_debug_apb.sv
verilog/reg_stage_top.sv
sim/tb_reg_stage.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_reg_stage &&
./obj_dir/Vtb_reg_stage ||
exit 1

/* sim/tb_reg_stage.sv */
// Register stage testbench
// Clock, reset, LFSR data source, compare tasks and APB driver
// Directed tests for x0, read/write, stall, decode masking and debug

`include "reg_stage_defs.svh"

module tb_reg_stage;

  import riscv_isa_pkg::*;

  localparam int XW     = `XLEN;
  localparam int ADDR_W = `DU_ADDR_W;
  // Rough length of all directed tests in cycles
  localparam int TEST_CYCLES    = 500;
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
  localparam int APB_MAX_WAIT   = 4;

  logic              clk_i;
  logic              rst_i;
  logic [XW-1:0]     instr_i;
  logic              stall_i;
  rsd_t              wb_dst_i;
  logic [XW-1:0]     wb_data_i;
  logic              wb_we_i;
  logic [XW-1:0]     src1_q_o;
  logic [XW-1:0]     src2_q_o;
  logic              illegal_o;
  logic              halted_o;
  logic [ADDR_W-1:0] paddr_i;
  logic              psel_i;
  logic              penable_i;
  logic              pwrite_i;
  logic [XW-1:0]     pwdata_i;
  logic [XW-1:0]     prdata_o;
  logic              pready_o;
  logic              pslverr_o;

  // Expected register contents
  logic [XW-1:0]     model [`RF_REGS];
  logic [31:0]       lfsr_state;
  string             cur_test;
  int                cycle_cnt;

  reg_stage_top #(
    .REGOUT (0)
  ) reg_stage_top_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .instr_i   (instr_i),
    .stall_i   (stall_i),
    .wb_dst_i  (wb_dst_i),
    .wb_data_i (wb_data_i),
    .wb_we_i   (wb_we_i),
    .src1_q_o  (src1_q_o),
    .src2_q_o  (src2_q_o),
    .illegal_o (illegal_o),
    .halted_o  (halted_o),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  // Period of 4
  always #2 clk_i = ~clk_i;

  // Watchdog
  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      abort_run($sformatf("Timeout after %0d cycles, tests did not finish", TIMEOUT_CYCLES));
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    begin
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  task automatic check_word(input string what, input logic [XW-1:0] exp,
                            input logic [XW-1:0] act);
    begin
      if (act !== exp)
        abort_run($sformatf("CHECK FAILED %s %s: expected 0x%08h actual 0x%08h",
                            cur_test, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    begin
      if (act !== exp)
        abort_run($sformatf("CHECK FAILED %s %s: expected %0b actual %0b",
                            cur_test, what, exp, act));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    begin
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
    end
  endfunction

  // One LFSR step per data bit
  task automatic next_rand(output logic [XW-1:0] w);
    begin
      w = '0;
      for (int b = 0; b < XW; b++)
      begin
        lfsr_state = lfsr_next(lfsr_state);
        w = {w[XW-2:0], lfsr_state[0]};
      end
    end
  endtask

  // R-type layout, funct fields zero
  function automatic logic [XW-1:0] make_instr(input opcode_e opc, input rsd_t rs1,
                                               input rsd_t rs2, input rsd_t rd);
    return {7'b0, rs2, rs1, 3'b0, rd, opc, 2'b11};
  endfunction

  // x0 always reads zero
  function automatic logic [XW-1:0] expect_reg(input int idx);
    return (idx == 0) ? '0 : model[idx];
  endfunction

  function automatic logic [ADDR_W-1:0] gpr_addr(input int idx);
    return `DU_GPR_BASE + ADDR_W'(4 * idx);
  endfunction

  task automatic wb_write(input int idx, input logic [XW-1:0] data);
    begin
      @(negedge clk_i);
      wb_dst_i  = rsd_t'(idx);
      wb_data_i = data;
      wb_we_i   = 1'b1;
      @(negedge clk_i);
      wb_we_i   = 1'b0;
      model[idx] = data;
    end
  endtask

  // Addresses latched at the next edge, sampled mid low phase after it
  task automatic present_instr(input logic [XW-1:0] instr);
    begin
      @(negedge clk_i);
      instr_i = instr;
      @(negedge clk_i);
      #1;
    end
  endtask

  task automatic check_operands(input string what, input int idx1, input int idx2);
    begin
      check_word({what, " src1"}, expect_reg(idx1), src1_q_o);
      check_word({what, " src2"}, expect_reg(idx2), src2_q_o);
    end
  endtask

  // One APB transfer, counts access cycles up to pready
  task automatic apb_access(input logic [ADDR_W-1:0] addr, input logic wr,
                            input logic [XW-1:0] wdata, output logic [XW-1:0] rdata,
                            output logic err, output int n_cycles);
    begin
      // Setup phase
      @(negedge clk_i);
      paddr_i   = addr;
      pwrite_i  = wr;
      pwdata_i  = wdata;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      // Access phase
      @(negedge clk_i);
      penable_i = 1'b1;
      n_cycles  = 1;
      #1;
      while (!pready_o)
      begin
        if (n_cycles >= APB_MAX_WAIT)
          abort_run($sformatf("APB transfer to 0x%03h got no pready within %0d cycles",
                              addr, APB_MAX_WAIT));
        @(negedge clk_i);
        n_cycles++;
        #1;
      end
      rdata = prdata_o;
      err   = pslverr_o;
      @(negedge clk_i);
      psel_i    = 1'b0;
      penable_i = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_x0_zero();
    logic [XW-1:0] v;
    begin
      cur_test = "test_x0_zero";
      next_rand(v);
      // Force a nonzero value into x0
      wb_write(0, {v[XW-1:1], 1'b1});
      present_instr(make_instr(OPC_OP, 5'd0, 5'd0, 5'd5));
      check_operands("x0 read", 0, 0);
    end
  endtask

  task automatic test_write_read();
    logic [XW-1:0] v;
    begin
      cur_test = "test_write_read";
      for (int i = 1; i < `RF_REGS; i++)
      begin
        next_rand(v);
        wb_write(i, v);
      end
      // Mirrored pairs so both ports see every register
      for (int i = 1; i < `RF_REGS; i++)
      begin
        present_instr(make_instr(OPC_OP, rsd_t'(i), rsd_t'(`RF_REGS - i), 5'd1));
        check_operands($sformatf("reg %0d", i), i, `RF_REGS - i);
      end
    end
  endtask

  task automatic test_stall_hold();
    begin
      cur_test = "test_stall_hold";
      present_instr(make_instr(OPC_OP, 5'd3, 5'd4, 5'd1));
      check_operands("before stall", 3, 4);
      @(negedge clk_i);
      stall_i = 1'b1;
      instr_i = make_instr(OPC_OP, 5'd7, 5'd8, 5'd1);
      repeat (3) @(negedge clk_i);
      #1;
      check_operands("during stall", 3, 4);
      @(negedge clk_i);
      stall_i = 1'b0;
      @(negedge clk_i);
      #1;
      check_operands("after release", 7, 8);
    end
  endtask

  task automatic test_decode_mask();
    logic [XW-1:0] ins;
    begin
      cur_test = "test_decode_mask";
      // No sources for upper immediate and JAL
      present_instr(make_instr(OPC_LUI, 5'd5, 5'd6, 5'd1));
      check_operands("lui", 0, 0);
      check_bit("lui illegal", 1'b0, illegal_o);
      present_instr(make_instr(OPC_JAL, 5'd5, 5'd6, 5'd1));
      check_operands("jal", 0, 0);
      present_instr(make_instr(OPC_STORE, 5'd9, 5'd10, 5'd0));
      check_operands("store", 9, 10);
      // Immediate form drops rs2
      present_instr(make_instr(OPC_OP_IMM, 5'd11, 5'd12, 5'd1));
      check_operands("op_imm", 11, 0);
      // Compressed length encoding
      ins = make_instr(OPC_OP, 5'd13, 5'd14, 5'd1);
      present_instr({ins[XW-1:2], 2'b00});
      check_bit("low bits 00 illegal", 1'b1, illegal_o);
      check_operands("illegal", 0, 0);
    end
  endtask

  task automatic test_debug_apb();
    logic [XW-1:0] v;
    logic [XW-1:0] rd;
    logic          err;
    int            n;
    begin
      cur_test = "test_debug_apb";
      next_rand(v);
      // Running pipeline rejects GPR writes
      apb_access(gpr_addr(5), 1'b1, v, rd, err, n);
      check_bit("gpr write running slverr", 1'b1, err);
      check_word("gpr write running cycles", XW'(1), XW'(n));
      present_instr(make_instr(OPC_OP, 5'd5, 5'd0, 5'd1));
      check_operands("reg 5 unchanged", 5, 0);
      // Halt request
      apb_access(`DU_CTRL_ADDR, 1'b1, XW'(1), rd, err, n);
      check_bit("ctrl write slverr", 1'b0, err);
      check_word("ctrl write cycles", XW'(1), XW'(n));
      check_bit("halted", 1'b1, halted_o);
      apb_access(`DU_CTRL_ADDR, 1'b0, '0, rd, err, n);
      check_word("ctrl read data", XW'(1), rd);
      check_word("ctrl read cycles", XW'(1), XW'(n));
      // Write then read back while halted
      apb_access(gpr_addr(6), 1'b1, v, rd, err, n);
      check_bit("gpr write slverr", 1'b0, err);
      check_word("gpr write cycles", XW'(1), XW'(n));
      model[6] = v;
      apb_access(gpr_addr(6), 1'b0, '0, rd, err, n);
      check_bit("gpr read slverr", 1'b0, err);
      check_word("gpr read data", expect_reg(6), rd);
      check_word("gpr read cycles", XW'(3), XW'(n));
      apb_access(gpr_addr(0), 1'b0, '0, rd, err, n);
      check_word("x0 read data", '0, rd);
      check_word("x0 read cycles", XW'(3), XW'(n));
    end
  endtask

  task automatic test_debug_priority();
    logic [XW-1:0] dbg;
    logic [XW-1:0] rd;
    logic          err;
    int            n;
    begin
      cur_test = "test_debug_priority";
      next_rand(dbg);
      // Pipeline write held through the APB access cycle
      @(negedge clk_i);
      wb_dst_i  = rsd_t'(9);
      wb_data_i = ~dbg;
      wb_we_i   = 1'b1;
      apb_access(gpr_addr(9), 1'b1, dbg, rd, err, n);
      wb_we_i   = 1'b0;
      check_bit("debug write slverr", 1'b0, err);
      model[9] = dbg;
      apb_access(gpr_addr(9), 1'b0, '0, rd, err, n);
      check_word("debug value kept", expect_reg(9), rd);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    clk_i      = 1'b0;
    rst_i      = 1'b1;
    instr_i    = make_instr(OPC_OP_IMM, 5'd0, 5'd0, 5'd0);
    stall_i    = 1'b0;
    wb_dst_i   = '0;
    wb_data_i  = '0;
    wb_we_i    = 1'b0;
    paddr_i    = '0;
    psel_i     = 1'b0;
    penable_i  = 1'b0;
    pwrite_i   = 1'b0;
    pwdata_i   = '0;
    lfsr_state = 32'd37;
    cycle_cnt  = 0;
    cur_test   = "reset";
    for (int i = 0; i < `RF_REGS; i++)
      model[i] = '0;
    repeat (8) @(negedge clk_i);
    rst_i = 1'b0;
    #1;
    check_bit("halted after reset", 1'b0, halted_o);
    check_bit("pready after reset", 1'b0, pready_o);
    check_bit("pslverr after reset", 1'b0, pslverr_o);
    test_x0_zero();
    test_write_read();
    test_stall_hold();
    test_decode_mask();
    test_debug_apb();
    test_debug_priority();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* verilog/reg_stage_top.sv */
// Register stage top
// Operand decoder, register file and APB debug unit

`include "reg_stage_defs.svh"

module reg_stage_top #(
  parameter int REGOUT = 0
)
(
  input  logic                  clk_i,
  input  logic                  rst_i,

  // Fetch side
  input  logic [`XLEN-1:0]      instr_i,
  input  logic                  stall_i,

  // Write back
  input  riscv_isa_pkg::rsd_t   wb_dst_i,
  input  logic [`XLEN-1:0]      wb_data_i,
  input  logic                  wb_we_i,

  // Operands to execute
  output logic [`XLEN-1:0]      src1_q_o,
  output logic [`XLEN-1:0]      src2_q_o,
  output logic                  illegal_o,
  output logic                  halted_o,

  // Debug APB
  input  logic [`DU_ADDR_W-1:0] paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`XLEN-1:0]      pwdata_i,
  output logic [`XLEN-1:0]      prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  import riscv_isa_pkg::*;

  rsd_t                  dec_src1;
  rsd_t                  dec_src2;
  logic                  halted;
  logic                  rf_stall;
  logic                  du_stall;
  logic                  du_we_rf;
  logic [`XLEN-1:0]      du_d;
  logic [`DU_ADDR_W-1:0] du_addr;
  logic [`XLEN-1:0]      du_rf_q;

  // Pipeline held by fetch back-pressure or debug halt
  assign rf_stall = stall_i | halted;
  assign halted_o = halted;

  // rd goes on with the instruction to later stages
  rf_operand_decode u_decode (
    .instr_i   (instr_i),
    .src1_o    (dec_src1),
    .src2_o    (dec_src2),
    .dst_o     (),
    .illegal_o (illegal_o)
  );

  riscv_rf #(
    .REGOUT (REGOUT)
  ) u_rf (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rf_src1_i   (dec_src1),
    .rf_src2_i   (dec_src2),
    .rf_src1_q_o (src1_q_o),
    .rf_src2_q_o (src2_q_o),
    .rf_dst_i    (wb_dst_i),
    .rf_dst_d_i  (wb_data_i),
    .rf_we_i     (wb_we_i),
    .stall_i     (rf_stall),
    .du_stall_i  (du_stall),
    .du_we_rf_i  (du_we_rf),
    .du_d_i      (du_d),
    .du_addr_i   (du_addr),
    .du_rf_q_o   (du_rf_q)
  );

  rf_debug_apb u_debug (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .halted_o   (halted),
    .du_stall_o (du_stall),
    .du_we_rf_o (du_we_rf),
    .du_d_o     (du_d),
    .du_addr_o  (du_addr),
    .du_rf_q_i  (du_rf_q)
  );

endmodule

/* verilog/rf_debug_apb.sv */
// Debug unit as an APB slave in front of the register file debug port
// Halt control word and GPR read/write sequencing

`include "reg_stage_defs.svh"

module rf_debug_apb
(
  input  logic                  clk_i,
  input  logic                  rst_i,

  // APB slave
  input  logic [`DU_ADDR_W-1:0] paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`XLEN-1:0]      pwdata_i,
  output logic [`XLEN-1:0]      prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,

  // Pipeline halt status
  output logic                  halted_o,

  // Register file debug port
  output logic                  du_stall_o,
  output logic                  du_we_rf_o,
  output logic [`XLEN-1:0]      du_d_o,
  output logic [`DU_ADDR_W-1:0] du_addr_o,
  input  logic [`XLEN-1:0]      du_rf_q_i
);

  import debug_pkg::*;

  // Size of the GPR window in bytes
  localparam int GPR_SPAN = 4 * `RF_REGS;
  localparam logic [`DU_ADDR_W-1:0] GPR_SPAN_W = GPR_SPAN[`DU_ADDR_W-1:0];

  du_state_e             state;
  du_sel_e               sel;
  logic                  halted;
  logic [`DU_ADDR_W-1:0] gpr_off;
  logic                  idle_acc;
  logic                  gpr_wr;
  logic                  gpr_rd;
  logic                  ctrl_acc;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Offset into GPR window that wraps below the base
  assign gpr_off = paddr_i - `DU_GPR_BASE;

  always_comb
  begin
    if (paddr_i == `DU_CTRL_ADDR)
      sel = DU_SEL_CTRL;
    else if (gpr_off < GPR_SPAN_W && gpr_off[1:0] == 2'b00)
      sel = DU_SEL_GPR;
    else
      sel = DU_SEL_NONE;
  end

  // Access phase seen while idle
  assign idle_acc = psel_i && penable_i && (state == DU_IDLE);
  assign gpr_wr   = idle_acc && (sel == DU_SEL_GPR) && pwrite_i;
  assign gpr_rd   = idle_acc && (sel == DU_SEL_GPR) && !pwrite_i;
  assign ctrl_acc = idle_acc && (sel == DU_SEL_CTRL);

  ////////////////////////////////////////
  // Halt flag and read sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      halted <= 1'b0;
    else if (ctrl_acc && pwrite_i)
      halted <= pwdata_i[0];
  end

  // GPR read steps through address latch, RF data and presentation
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state <= DU_IDLE;
    else
    begin
      case (state)
        DU_IDLE:
          if (gpr_rd)
            state <= DU_RD_ADDR;
        DU_RD_ADDR:
          state <= DU_RD_DATA;
        DU_RD_DATA:
          state <= DU_DONE;
        default:
          state <= DU_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Register file side
  ////////////////////////////////////////

  // Hold port 1 on the debug address for the whole read
  assign du_stall_o = gpr_rd || (state == DU_RD_ADDR);
  // Writes only land while halted
  assign du_we_rf_o = gpr_wr && halted;
  assign du_d_o     = pwdata_i;
  // Byte offset to word index
  assign du_addr_o  = {2'b00, gpr_off[`DU_ADDR_W-1:2]};

  ////////////////////////////////////////
  // APB response
  ////////////////////////////////////////

  // Everything but GPR reads completes in the first access cycle
  assign pready_o  = (idle_acc && !gpr_rd) || (state == DU_RD_DATA);
  // Unmapped address or GPR write with the pipeline running
  assign pslverr_o = idle_acc && ((sel == DU_SEL_NONE) || (gpr_wr && !halted));

  always_comb
  begin
    if (state == DU_RD_DATA)
      prdata_o = du_rf_q_i;
    else if (ctrl_acc && !pwrite_i)
      prdata_o = {{(`XLEN-1){1'b0}}, halted};
    else
      prdata_o = '0;
  end

  assign halted_o = halted;

  // Ready only answers an access phase
  a_pready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
    pready_o |-> (psel_i && penable_i));

  // Requester holds a GPR read until its data is presented
  a_gpr_rd_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (state == DU_RD_ADDR || state == DU_RD_DATA)
    |-> (psel_i && penable_i && !pwrite_i && $stable(paddr_i)));

endmodule

/* verilog/riscv_rf.sv */
// Integer register file with two read ports and one write port
// Read addresses held while stalled and x0 reading as zero
// Optional output register and debug access on read port 1

`include "reg_stage_defs.svh"

module riscv_rf #(
  parameter int REGOUT = 0
)
(
  input  logic                  clk_i,
  input  logic                  rst_i,

  // Read ports
  input  riscv_isa_pkg::rsd_t   rf_src1_i,
  input  riscv_isa_pkg::rsd_t   rf_src2_i,
  output logic [`XLEN-1:0]      rf_src1_q_o,
  output logic [`XLEN-1:0]      rf_src2_q_o,

  // Write port, from later stages
  input  riscv_isa_pkg::rsd_t   rf_dst_i,
  input  logic [`XLEN-1:0]      rf_dst_d_i,
  input  logic                  rf_we_i,
  input  logic                  stall_i,

  // Debug access
  input  logic                  du_stall_i,
  input  logic                  du_we_rf_i,
  input  logic [`XLEN-1:0]      du_d_i,
  input  logic [`DU_ADDR_W-1:0] du_addr_i,
  output logic [`XLEN-1:0]      du_rf_q_o
);

  import riscv_isa_pkg::*;

  // Storage for all entries including x0
  logic [`XLEN-1:0] mem [`RF_REGS];

  rsd_t             src1;
  rsd_t             src2;
  rsd_t             du_idx;
  logic             src1_is_x0;
  logic             src2_is_x0;
  logic [`XLEN-1:0] rfout1;
  logic [`XLEN-1:0] rfout2;
  logic [`XLEN-1:0] dout1;
  logic [`XLEN-1:0] dout2;
  logic             dst_is_src1;
  logic             dst_is_src2;

  // Register index from the debug word address
  assign du_idx = du_addr_i[$bits(rsd_t)-1:0];

  ////////////////////////////////////////
  // Read address registers
  ////////////////////////////////////////

  // Port 1 takes the debug address over the pipeline source
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      src1       <= '0;
      src1_is_x0 <= 1'b1;
    end
    else if (du_stall_i)
    begin
      src1       <= du_idx;
      src1_is_x0 <= ~|du_idx;
    end
    else if (!stall_i)
    begin
      src1       <= rf_src1_i;
      src1_is_x0 <= ~|rf_src1_i;
    end
  end

  // Port 2 follows the pipeline only
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      src2       <= '0;
      src2_is_x0 <= 1'b1;
    end
    else if (!stall_i)
    begin
      src2       <= rf_src2_i;
      src2_is_x0 <= ~|rf_src2_i;
    end
  end

  // Write port matching a latched read address
  assign dst_is_src1 = (rf_dst_i == src1);
  assign dst_is_src2 = (rf_dst_i == src2);

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  assign rfout1 = mem[src1];
  assign rfout2 = mem[src2];

  // x0 masked to zero whatever its entry holds
  assign dout1 = src1_is_x0 ? '0 : rfout1;
  assign dout2 = src2_is_x0 ? '0 : rfout2;

  if (REGOUT > 0)
  begin : g_regout
    // Extra pipeline register frozen by stall
    always_ff @(posedge clk_i)
    begin
      if (!stall_i)
      begin
        rf_src1_q_o <= dout1;
        rf_src2_q_o <= dout2;
      end
    end
  end
  else
  begin : g_comb_out
    assign rf_src1_q_o = dout1;
    assign rf_src2_q_o = dout2;
  end

  // Debug read data one cycle after the address
  always_ff @(posedge clk_i)
  begin
    du_rf_q_o <= dout1;
  end

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Debug write has priority and lands during stall too
  always_ff @(posedge clk_i)
  begin
    if (du_we_rf_i)
      mem[du_idx] <= du_d_i;
    else if (rf_we_i)
      mem[rf_dst_i] <= rf_dst_d_i;
  end

  // Debug and pipeline writes only meet while the pipeline is held
  a_wr_collide_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (du_we_rf_i && rf_we_i) |-> stall_i);

endmodule

/* verilog/rf_operand_decode.sv */
// Operand decoder
// Pulls rs1, rs2 and rd out of the instruction word
// Sources not used by the opcode are steered to x0

`include "reg_stage_defs.svh"

module rf_operand_decode
(
  input  logic [`XLEN-1:0]      instr_i,
  output riscv_isa_pkg::rsd_t   src1_o,
  output riscv_isa_pkg::rsd_t   src2_o,
  output riscv_isa_pkg::rsd_t   dst_o,
  output logic                  illegal_o
);

  import riscv_isa_pkg::*;

  opcode_e opcode;
  logic    use_rs1;
  logic    use_rs2;
  logic    use_rd;
  logic    bad;

  // Major opcode field
  assign opcode = opcode_e'(instr_i[6:2]);

  ////////////////////////////////////////
  // Operand usage per opcode
  ////////////////////////////////////////

  always_comb
  begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    bad     = 1'b0;
    case (opcode)
      // Immediate only, no sources
      OPC_LUI, OPC_AUIPC, OPC_JAL:
        use_rd = 1'b1;
      // One source and a destination
      OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_SYSTEM:
      begin
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      // Two sources, nothing written back
      OPC_BRANCH, OPC_STORE:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      // Register-register ALU
      OPC_OP:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
      end
      default:
        bad = 1'b1;
    endcase
    // Compressed or reserved length encodings
    if (instr_i[1:0] != 2'b11)
      bad = 1'b1;
  end

  // Unused or illegal fields read as x0
  assign src1_o    = (use_rs1 && !bad) ? instr_i[19:15] : '0;
  assign src2_o    = (use_rs2 && !bad) ? instr_i[24:20] : '0;
  assign dst_o     = (use_rd && !bad) ? instr_i[11:7] : '0;
  assign illegal_o = bad;

endmodule

/* verilog/debug_pkg.sv */
// Debug unit types
// Sequencer states and decoded APB targets

package debug_pkg;

  ////////////////////////////////////////
  // Debug sequencer
  ////////////////////////////////////////

  // GPR reads take three access cycles
  typedef enum logic [1:0] {
    DU_IDLE    = 2'd0,  // Waiting, single cycle accesses answered here
    DU_RD_ADDR = 2'd1,  // Address latched, RF output being registered
    DU_RD_DATA = 2'd2,  // Read data presented with pready
    DU_DONE    = 2'd3   // Transfer closed, back to idle
  } du_state_e;

  ////////////////////////////////////////
  // APB address decode
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    DU_SEL_GPR  = 2'd0,
    DU_SEL_CTRL = 2'd1,
    DU_SEL_NONE = 2'd2
  } du_sel_e;

endpackage

/* verilog/riscv_isa_pkg.sv */
// Instruction set types for the register stage
// Register index and major opcode encoding

`include "reg_stage_defs.svh"

package riscv_isa_pkg;

  ////////////////////////////////////////
  // Register index
  ////////////////////////////////////////

  // Wide enough to address every GPR
  typedef logic [$clog2(`RF_REGS)-1:0] rsd_t;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////

  // Encoded as instruction bits 6:2
  // Bits 1:0 must be 11 for a 32-bit instruction
  typedef enum logic [4:0] {
    // Upper immediates
    OPC_LUI    = 5'b01101,
    OPC_AUIPC  = 5'b00101,
    // Jumps and branches
    OPC_JAL    = 5'b11011,
    OPC_JALR   = 5'b11001,
    OPC_BRANCH = 5'b11000,
    // Memory
    OPC_LOAD   = 5'b00000,
    OPC_STORE  = 5'b01000,
    // Arithmetic, immediate and register forms
    OPC_OP_IMM = 5'b00100,
    OPC_OP     = 5'b01100,
    // ECALL, EBREAK and CSR accesses
    OPC_SYSTEM = 5'b11100
  } opcode_e;

endpackage

/* verilog/reg_stage_defs.svh */
// Register stage shared macros
// Data width, register count and debug APB address map

`ifndef REG_STAGE_DEFS_SVH
`define REG_STAGE_DEFS_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

// Integer register width
`define XLEN          32
// Number of architectural registers, x0 included
`define RF_REGS       32

////////////////////////////////////////
// Debug APB map
////////////////////////////////////////

`define DU_ADDR_W     12
// GPR window, register n at byte 4n
`define DU_GPR_BASE   12'h000
// Control word, bit 0 requests halt
`define DU_CTRL_ADDR  12'h100

`endif
